/* ps2_keyboard.f */
design/ps2_pkg.sv
design/ps2_line_filter.sv
design/ps2_rx.sv
design/ps2_key_decoder.sv
design/ps2_event_fifo.sv
design/ps2_keyboard.sv
sim/ps2_keyboard_assertions.sv
sim/ps2_keyboard_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the result in sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ps2_keyboard_tb \
    -f ps2_keyboard.f -o ps2_keyboard_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/ps2_keyboard_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

/* sim/ps2_keyboard_tests.txt */
// frames, 8 x (byte, corrupt: 0 good, 1 parity flipped, 2 stop low), {left, listed},
// then 4 events as {code, extended, released}; a line starting with ff ends the list
// plain make codes
03 1c 0 32 0 21 0 00 0 00 0 00 0 00 0 00 0 03 070 0c8 084 000
// release, extended, extended release
02 f0 0 1c 0 00 0 00 0 00 0 00 0 00 0 00 0 01 071 000 000 000
02 e0 0 75 0 00 0 00 0 00 0 00 0 00 0 00 0 01 1d6 000 000 000
03 e0 0 f0 0 75 0 00 0 00 0 00 0 00 0 00 0 01 1d7 000 000 000
// parity error, then a good frame
02 1c 1 32 0 00 0 00 0 00 0 00 0 00 0 00 0 01 0c8 000 000 000
// missing stop after e0 drops the extended flag
03 e0 0 75 2 75 0 00 0 00 0 00 0 00 0 00 0 01 1d4 000 000 000
03 f0 0 1c 1 1c 0 00 0 00 0 00 0 00 0 00 0 01 070 000 000 000
// ten codes without a pop, two are dropped
08 15 0 1d 0 24 0 2d 0 2c 0 35 0 3c 0 43 0 80 000 000 000 000
02 44 0 4d 0 00 0 00 0 00 0 00 0 00 0 00 0 44 054 074 090 0b4
00 00 0 00 0 00 0 00 0 00 0 00 0 00 0 00 0 04 0b0 0d4 0f0 10c
// pop into an empty queue
00 00 0 00 0 00 0 00 0 00 0 00 0 00 0 00 0 00 000 000 000 000
// e1 passes through as a plain code
04 e1 0 e0 0 f0 0 1f 0 00 0 00 0 00 0 00 0 02 384 07f 000 000
ff

/* sim/ps2_keyboard_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_keyboard_tb import ps2_pkg::*; ();

    localparam int HALF_BIT   = 20;   // clk_in cycles per ps2 clock phase.
    localparam int REC_W      = 22;   // words per test line.
    localparam int MAX_TESTS  = 32;
    localparam int EVENT_WAIT = 50;
    localparam logic [9:0] END_MARK = 10'h0ff;

    logic       clk_in;
    logic       rst_in;
    logic       ps2_clk_in;
    logic       ps2_data_in;
    logic       pop_in;
    key_event_t event_out;
    logic       event_valid_out;
    logic       frame_error_out;
    logic       overflow_out;

    logic [9:0] tests_mem [0:MAX_TESTS*REC_W-1];
    int num_tests = 0;
    int errors = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int err_seen = 0;
    int ovf_seen = 0;
    int held = 0;   // events left queued by the previous line.

    ps2_keyboard UUT (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .ps2_clk_in      (ps2_clk_in),
        .ps2_data_in     (ps2_data_in),
        .pop_in          (pop_in),
        .event_out       (event_out),
        .event_valid_out (event_valid_out),
        .frame_error_out (frame_error_out),
        .overflow_out    (overflow_out)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    always @(negedge clk_in) begin
        if (frame_error_out) begin
            err_seen++;
        end
        if (overflow_out) begin
            ovf_seen++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic pop_event();
        @(posedge clk_in);
        pop_in <= 1'b1;
        @(posedge clk_in);
        pop_in <= 1'b0;
        @(negedge clk_in);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic [1:0] corrupt);
        logic [10:0] bits;
        int i;
        bits = {1'b1, ~^data, data, 1'b0};   // stop, odd parity, data, start.
        if (corrupt == 2'd1) begin
            bits[9] = ~bits[9];
        end
        if (corrupt == 2'd2) begin
            bits[10] = 1'b0;
        end
        for (i = 0; i < 11; i++) begin
            @(posedge clk_in);
            ps2_data_in <= bits[i];
            repeat (HALF_BIT) @(posedge clk_in);
            ps2_clk_in <= 1'b0;
            repeat (HALF_BIT) @(posedge clk_in);
            ps2_clk_in <= 1'b1;
        end
        @(posedge clk_in);
        ps2_data_in <= 1'b1;   // bus released.
        repeat (HALF_BIT) @(posedge clk_in);
    endtask

    task automatic run_test(input int t);
        int base;
        int i;
        int listed;
        int left;
        int exp_err;
        int exp_ovf;
        int produced;
        int err_start;
        int ovf_start;
        int errors_start;
        int wait_cnt;
        logic [7:0] code;
        logic [1:0] corrupt;
        base = t * REC_W;
        listed = int'(tests_mem[base+17][3:0]);
        left = int'(tests_mem[base+17][7:4]);
        exp_err = 0;
        produced = 0;
        errors_start = errors;
        @(posedge clk_in);
        err_start = err_seen;
        ovf_start = ovf_seen;
        for (i = 0; i < int'(tests_mem[base]); i++) begin
            code = tests_mem[base+1+2*i][7:0];
            corrupt = tests_mem[base+2+2*i][1:0];
            if (corrupt != 2'd0) begin
                exp_err++;
            end else if (code != PREFIX_EXT && code != PREFIX_BREAK) begin
                produced++;   // a plain code makes one event.
            end
            send_frame(code, corrupt);
        end
        repeat (HALF_BIT) @(posedge clk_in);
        exp_ovf = (held + produced > FIFO_DEPTH) ? held + produced - FIFO_DEPTH : 0;
        check_value(err_seen - err_start, exp_err, "frame error pulses");
        check_value(ovf_seen - ovf_start, exp_ovf, "overflow pulses");
        for (i = 0; i < listed; i++) begin
            wait_cnt = 0;
            @(negedge clk_in);
            while (!event_valid_out && wait_cnt < EVENT_WAIT) begin
                @(negedge clk_in);
                wait_cnt++;
            end
            if (!event_valid_out) begin
                $display("test %0d: event %0d never arrived", t + 1, i + 1);
                errors++;
            end else begin
                check_value(32'(event_out), 32'(tests_mem[base+18+i]), "key event");
                pop_event();
            end
        end
        @(negedge clk_in);
        check_value(32'(event_valid_out), 32'(left != 0), "event valid after pops");
        if (left == 0) begin
            pop_event();   // pop with nothing queued.
            check_value(32'(event_valid_out), 0, "event valid after empty pop");
        end
        held = left;
        if (errors == errors_start) begin
            $display("test %0d: pass", t + 1);
            pass_cnt++;
        end else begin
            $display("test %0d: fail, %0d errors", t + 1, errors - errors_start);
            fail_cnt++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int t;
        rst_in      <= 1'b1;
        ps2_clk_in  <= 1'b1;
        ps2_data_in <= 1'b1;
        pop_in      <= 1'b0;
        $readmemh("sim/ps2_keyboard_tests.txt", tests_mem);
        while (num_tests < MAX_TESTS && tests_mem[num_tests*REC_W] != END_MARK) begin
            num_tests++;
        end
        repeat (3) @(posedge clk_in);
        rst_in <= 1'b0;
        @(negedge clk_in);
        check_value(32'(event_valid_out), 0, "event valid after reset");
        check_value(32'(frame_error_out), 0, "frame error after reset");
        check_value(32'(overflow_out), 0, "overflow after reset");
        check_value(32'(event_out), 0, "event out after reset");
        if (errors == 0) begin
            $display("reset check: pass");
            pass_cnt++;
        end else begin
            $display("reset check: fail");
            fail_cnt++;
        end
        for (t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        if (UUT.checks.fail_count != 0) begin
            $display("%0d assertion failures were reported", UUT.checks.fail_count);
            fail_cnt++;
        end
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog sized for 12 frames per test line.
    initial begin
        longint limit_ns;
        #1;
        limit_ns = longint'(num_tests) * 12 * 11 * 40 * 4 * 2 + 1000;
        #(limit_ns);
        $display("timeout: the tests did not finish within %0d ns", limit_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/ps2_keyboard_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_keyboard_assertions (
    input wire clk_in,
    input wire rst_in,
    input wire event_valid,
    input wire frame_error,
    input wire overflow,
    input wire byte_valid
);

    int fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one-cycle strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    error_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
        frame_error |=> !frame_error)
    else begin
        fail_count++;
        $error("frame_error_out held high for two cycles");
    end

    overflow_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
        overflow |=> !overflow)
    else begin
        fail_count++;
        $error("overflow_out held high for two cycles");
    end

    // outputs idle right after reset.
    reset_quiet: assert property (@(posedge clk_in)
        $fell(rst_in) |-> (!event_valid && !frame_error && !overflow))
    else begin
        fail_count++;
        $error("strobes not low after reset");
    end

    byte_or_error: assert property (@(posedge clk_in) disable iff (rst_in)
        !(byte_valid && frame_error))
    else begin
        fail_count++;
        $error("byte valid and frame error together");
    end

endmodule

bind ps2_keyboard ps2_keyboard_assertions checks (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .event_valid (event_valid_out),
    .frame_error (frame_error_out),
    .overflow    (overflow_out),
    .byte_valid  (byte_valid)
);

`default_nettype wire

/* design/ps2_keyboard.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_keyboard import ps2_pkg::*; (
    input wire         clk_in,
    input wire         rst_in,
    input wire         ps2_clk_in,
    input wire         ps2_data_in,
    input wire         pop_in,
    output key_event_t event_out,
    output logic       event_valid_out,
    output logic       frame_error_out,
    output logic       overflow_out
);

    logic       clk_fall;
    logic       data_level;
    logic       byte_valid;
    scancode_t  rx_byte;
    logic       key_valid;
    key_event_t key;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line conditioning
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ps2_line_filter clk_filter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .line_in   (ps2_clk_in),
        .level_out (),
        .fall_out  (clk_fall)       // bit strobe.
    );

    ps2_line_filter data_filter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .line_in   (ps2_data_in),
        .level_out (data_level),
        .fall_out  ()
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame, key and queue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ps2_rx rx (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .bit_strobe_in   (clk_fall),
        .bit_in          (data_level),
        .byte_valid_out  (byte_valid),
        .byte_out        (rx_byte),
        .frame_error_out (frame_error_out)
    );

    ps2_key_decoder decoder (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .byte_valid_in  (byte_valid),
        .byte_in        (rx_byte),
        .frame_error_in (frame_error_out),
        .key_valid_out  (key_valid),
        .key_out        (key)
    );

    ps2_event_fifo fifo (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .push_in       (key_valid),
        .push_data_in  (key),
        .pop_in        (pop_in),
        .head_out      (event_out),
        .not_empty_out (event_valid_out),
        .overflow_out  (overflow_out)
    );

endmodule

`default_nettype wire

/* design/ps2_event_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_event_fifo import ps2_pkg::*; (
    input wire         clk_in,
    input wire         rst_in,
    input wire         push_in,
    input key_event_t  push_data_in,
    input wire         pop_in,
    output key_event_t head_out,
    output logic       not_empty_out,
    output logic       overflow_out
);

    key_event_t  mem [FIFO_DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        full;
    logic        pop_fire;
    logic        push_fire;

    assign full          = (count == fifo_count_t'(FIFO_DEPTH));
    assign not_empty_out = (count != '0);
    assign pop_fire      = pop_in && not_empty_out;
    assign push_fire     = push_in && (!full || pop_fire);   // full, but a slot frees now.
    assign head_out      = not_empty_out ? mem[rd_ptr] : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            overflow_out <= 1'b0;
        end else begin
            overflow_out <= push_in && !push_fire;   // dropped event.
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data_in;
        end
    end

endmodule

`default_nettype wire

/* design/ps2_key_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_key_decoder import ps2_pkg::*; (
    input wire        clk_in,
    input wire        rst_in,
    input wire        byte_valid_in,
    input scancode_t  byte_in,
    input wire        frame_error_in,
    output logic      key_valid_out,
    output key_event_t key_out
);

    logic pend_ext;
    logic pend_rel;
    logic is_ext;
    logic is_break;

    assign is_ext   = (byte_in == PREFIX_EXT);
    assign is_break = (byte_in == PREFIX_BREAK);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // prefix tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pend_ext      <= 1'b0;
            pend_rel      <= 1'b0;
            key_valid_out <= 1'b0;
        end else begin
            key_valid_out <= 1'b0;
            if (frame_error_in) begin
                // a broken sequence must not mark the next key.
                pend_ext <= 1'b0;
                pend_rel <= 1'b0;
            end else if (byte_valid_in) begin
                if (is_ext) begin
                    pend_ext <= 1'b1;
                end else if (is_break) begin
                    pend_rel <= 1'b1;
                end else begin
                    key_valid_out <= 1'b1;
                    pend_ext      <= 1'b0;
                    pend_rel      <= 1'b0;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // event payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_in) begin
        if (byte_valid_in && !frame_error_in && !is_ext && !is_break) begin
            key_out.code     <= byte_in;
            key_out.extended <= pend_ext;   // flags gathered so far.
            key_out.released <= pend_rel;
        end
    end

endmodule

`default_nettype wire

/* design/ps2_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_rx import ps2_pkg::*; (
    input wire        clk_in,
    input wire        rst_in,
    input wire        bit_strobe_in,
    input wire        bit_in,
    output logic      byte_valid_out,
    output scancode_t byte_out,
    output logic      frame_error_out
);

    rx_state_t  state;
    bit_index_t bit_idx;
    scancode_t  shift_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state           <= IDLE;
            bit_idx         <= '0;
            byte_valid_out  <= 1'b0;
            frame_error_out <= 1'b0;
        end else begin
            byte_valid_out  <= 1'b0;
            frame_error_out <= 1'b0;
            if (bit_strobe_in) begin
                case (state)
                    IDLE: begin
                        // start bit is low, a high one is not a frame.
                        if (!bit_in) begin
                            bit_idx <= '0;
                            state   <= RECEIVE;
                        end
                    end
                    RECEIVE: begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    PARITY: begin
                        // odd parity over data and parity bit.
                        if (^{shift_q, bit_in}) begin
                            state <= STOP;
                        end else begin
                            frame_error_out <= 1'b1;
                            state           <= IDLE;
                        end
                    end
                    STOP: begin
                        if (bit_in) begin
                            byte_valid_out <= 1'b1;
                        end else begin
                            frame_error_out <= 1'b1;   // stop bit missing.
                        end
                        state <= IDLE;
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_in) begin
        if (bit_strobe_in && (state == RECEIVE)) begin
            shift_q <= {bit_in, shift_q[SCANCODE_W-1:1]};   // lsb arrives first.
        end
        if (bit_strobe_in && (state == STOP) && bit_in) begin
            byte_out <= shift_q;
        end
    end

endmodule

`default_nettype wire

/* design/ps2_line_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module ps2_line_filter import ps2_pkg::*; (
    input wire    clk_in,
    input wire    rst_in,
    input wire    line_in,
    output logic  level_out,
    output logic  fall_out
);

    logic          sync_1;
    logic          sync_2;
    debounce_cnt_t stable_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // synchronizer, idles high like the bus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sync_1 <= 1'b1;
            sync_2 <= 1'b1;
        end else begin
            sync_1 <= line_in;
            sync_2 <= sync_1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // debouncer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            level_out  <= 1'b1;
            fall_out   <= 1'b0;
            stable_cnt <= '0;
        end else begin
            fall_out <= 1'b0;
            if (sync_2 != level_out) begin
                if (stable_cnt == debounce_cnt_t'(DEBOUNCE_CYCLES - 1)) begin
                    level_out  <= sync_2;
                    fall_out   <= level_out;   // only a high to low move strobes.
                    stable_cnt <= '0;
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end else begin
                stable_cnt <= '0;   // glitch, start over.
            end
        end
    end

endmodule

`default_nettype wire

/* design/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes and timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int SCANCODE_W      = 8;
    localparam int DEBOUNCE_CYCLES = 4;   // cycles a new level must hold.
    localparam int DEBOUNCE_W      = 3;
    localparam int FIFO_DEPTH      = 8;
    localparam int FIFO_PTR_W      = 3;

    typedef logic [SCANCODE_W-1:0] scancode_t;
    typedef logic [DEBOUNCE_W-1:0] debounce_cnt_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_PTR_W:0]   fifo_count_t;  // one wider, holds a full count.
    typedef logic [2:0]            bit_index_t;   // data bit within a frame.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scan code set 2 prefixes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam scancode_t PREFIX_EXT   = 8'hE0;
    localparam scancode_t PREFIX_BREAK = 8'hF0;

    // frame receiver states.
    typedef enum logic [1:0] {
        IDLE,
        RECEIVE,
        PARITY,
        STOP
    } rx_state_t;

    // one decoded key, code in the upper byte.
    typedef struct packed {
        scancode_t code;
        logic      extended;
        logic      released;   // break code, key let go.
    } key_event_t;

endpackage

`default_nettype wire
